// ==== Bender.yml ====
package:
  name: icache

sources:
  - icache_pkg.sv
  - icache_ram.sv
  - icache_tag_array.sv
  - icache_data_array.sv
  - icache_ctrl.sv
  - icache_top.sv
  - target: simulation
    files:
      - tb_icache.sv

// ==== icache_ctrl.sv ====
/* Cache controller: lookup, refill and invalidate FSM, LRU update and hit word select.
   Drives both memory arrays and all CPU, memory and SPR handshakes. */
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
  input  logic                               clk,
  input  logic                               rst,
  // CPU fetch
  input  logic                               cpu_req_i,
  input  logic [icache_pkg::ADDR_W-1:0]      cpu_adr_i,
  output logic                               cpu_ack_o,
  output icache_pkg::word_t                  cpu_dat_o,
  // Refill memory
  output logic                               refill_req_o,
  output logic [icache_pkg::ADDR_W-1:0]      refill_adr_o,
  input  logic                               mem_we_i,
  input  icache_pkg::word_t                  mem_dat_i,
  output logic                               refill_done_o,
  // SPR bus
  input  logic                               spr_stb_i,
  input  logic                               spr_we_i,
  input  logic [15:0]                        spr_addr_i,
  input  logic [icache_pkg::ADDR_W-1:0]      spr_dat_i,
  output logic                               spr_ack_o,
  // Tag array
  output icache_pkg::set_t                   tag_rd_set_o,
  output icache_pkg::tag_t                   cmp_tag_o,
  output icache_pkg::set_t                   tag_wr_set_o,
  output logic                               tag_wr_en_o,
  output icache_pkg::tag_row_t               tag_wr_row_o,
  input  icache_pkg::tag_row_t               rd_row_i,
  input  logic [icache_pkg::NUM_WAYS-1:0]    way_hit_i,
  // Data array
  output icache_pkg::data_adr_t              data_rd_adr_o,
  output icache_pkg::data_adr_t              data_wr_adr_o,
  output logic [icache_pkg::NUM_WAYS-1:0]    data_wr_way_o,
  output icache_pkg::word_t                  data_wr_dat_o,
  input  icache_pkg::word_t                  rd_dat0_i,
  input  icache_pkg::word_t                  rd_dat1_i
);

  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    REFILL,
    INVALIDATE
  } state_e;

  state_e state_q;
  state_e state_d;

  // Registered lookup address, also the miss address during refill
  icache_pkg::tag_t      tag_q;
  icache_pkg::set_t      set_q;
  icache_pkg::word_sel_t word_q;

  // Miss context
  logic                  victim_q;
  icache_pkg::tag_row_t  save_row_q;
  icache_pkg::word_sel_t cnt_q;

  icache_pkg::set_t      inv_set_q;

  // LRU bit written in the same cycle its set was read
  logic                  fwd_q;
  logic                  fwd_lru_q;

  logic hit;
  logic lru_eff;
  logic lookup_take;
  logic inv_take;
  logic refill_last;

  ////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////

  assign hit = |way_hit_i;

  // Tag RAM has no bypass, so take a just-written LRU from the side register
  assign lru_eff = fwd_q ? fwd_lru_q : rd_row_i.lru;

  // Block invalidate write, only from IDLE
  assign inv_take = (state_q == IDLE) && spr_stb_i && spr_we_i &&
                    (spr_addr_i == icache_pkg::SPR_ICBIR_ADDR);

  assign refill_last = (state_q == REFILL) && mem_we_i &&
                       (cnt_q == icache_pkg::word_sel_t'(icache_pkg::WORDS_PER_LINE - 1));

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        // Invalidate wins over a request in the same cycle
        if (inv_take) begin
          state_d = INVALIDATE;
        end else if (cpu_req_i) begin
          state_d = LOOKUP;
        end
      end
      LOOKUP: begin
        // Requests in the miss cycle are dropped
        if (!hit) begin
          state_d = REFILL;
        end else if (cpu_req_i) begin
          state_d = LOOKUP;
        end else begin
          state_d = IDLE;
        end
      end
      REFILL: begin
        if (refill_last) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // A request is taken whenever the next state is LOOKUP
  assign lookup_take = (state_d == LOOKUP);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
      cnt_q   <= '0;
      fwd_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      // Refill word count, restarts outside REFILL
      if (state_q != REFILL) begin
        cnt_q <= '0;
      end else if (mem_we_i) begin
        cnt_q <= cnt_q + 1'b1;
      end
      fwd_q <= tag_wr_en_o && (tag_wr_set_o == tag_rd_set_o);
    end
  end

  // Payload and context registers
  always_ff @(posedge clk) begin
    if (lookup_take) begin
      tag_q  <= icache_pkg::adr_tag(cpu_adr_i);
      set_q  <= icache_pkg::adr_set(cpu_adr_i);
      word_q <= icache_pkg::adr_word(cpu_adr_i);
    end
    // Victim and row snapshot at the miss
    if ((state_q == LOOKUP) && !hit) begin
      victim_q   <= lru_eff;
      save_row_q <= rd_row_i;
    end
    if (inv_take) begin
      inv_set_q <= icache_pkg::adr_set(spr_dat_i);
    end
    fwd_lru_q <= tag_wr_row_o.lru;
  end

  ////////////////////////////////////////////////////////////
  // Memory reads and CPU side
  ////////////////////////////////////////////////////////////

  // Both arrays read the incoming address every cycle
  assign tag_rd_set_o  = icache_pkg::adr_set(cpu_adr_i);
  assign data_rd_adr_o = {icache_pkg::adr_set(cpu_adr_i), icache_pkg::adr_word(cpu_adr_i)};
  assign cmp_tag_o     = tag_q;

  assign cpu_ack_o = (state_q == LOOKUP) && hit;
  assign cpu_dat_o = way_hit_i[1] ? rd_dat1_i : rd_dat0_i;

  ////////////////////////////////////////////////////////////
  // Refill and SPR handshakes
  ////////////////////////////////////////////////////////////

  assign refill_req_o  = (state_q == REFILL);
  assign refill_adr_o  = {tag_q, set_q, word_q, 2'b00};
  assign refill_done_o = refill_last;
  assign spr_ack_o     = (state_q == INVALIDATE);

  // Missed word first, wrapping inside the line
  assign data_wr_adr_o = {set_q, icache_pkg::word_sel_t'(word_q + cnt_q)};
  assign data_wr_dat_o = mem_dat_i;
  assign data_wr_way_o = ((state_q == REFILL) && mem_we_i) ?
                         (icache_pkg::NUM_WAYS'(1) << victim_q) : '0;

  ////////////////////////////////////////////////////////////
  // Tag row writes
  ////////////////////////////////////////////////////////////

  always_comb begin
    tag_wr_en_o  = 1'b0;
    tag_wr_set_o = set_q;
    tag_wr_row_o = rd_row_i;
    case (state_q)
      LOOKUP: begin
        // Hit on way 0 points LRU at way 1 and vice versa
        if (hit) begin
          tag_wr_en_o      = 1'b1;
          tag_wr_row_o.lru = way_hit_i[0];
        end
      end
      REFILL: begin
        tag_wr_row_o = save_row_q;
        // First word drops the victim line
        if (mem_we_i && (cnt_q == '0)) begin
          tag_wr_en_o                       = 1'b1;
          tag_wr_row_o.way[victim_q].valid = 1'b0;
        end
        // Last word installs the new tag
        if (refill_last) begin
          tag_wr_en_o                       = 1'b1;
          tag_wr_row_o.way[victim_q].valid = 1'b1;
          tag_wr_row_o.way[victim_q].tag   = tag_q;
          tag_wr_row_o.lru                 = !victim_q;
        end
      end
      INVALIDATE: begin
        // Clear both ways and the LRU bit
        tag_wr_en_o  = 1'b1;
        tag_wr_set_o = inv_set_q;
        tag_wr_row_o = '0;
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== icache_data_array.sv ====
/* Instruction word storage for both ways, addressed by set and word.
   Both ways read in parallel; refill writes one way picked by a one-hot select. */
`timescale 1ns/1ps
`default_nettype none

module icache_data_array (
  input  logic                             clk,
  input  icache_pkg::data_adr_t            rd_adr_i,
  input  icache_pkg::data_adr_t            wr_adr_i,
  input  logic [icache_pkg::NUM_WAYS-1:0] wr_way_i,
  input  icache_pkg::word_t                wr_dat_i,
  output icache_pkg::word_t                rd_dat0_o,
  output icache_pkg::word_t                rd_dat1_o
);

  // Read data per way
  icache_pkg::word_t rd_dat [icache_pkg::NUM_WAYS];

  ////////////////////////////////////////////////////////////
  // Way memories
  ////////////////////////////////////////////////////////////

  for (genvar w = 0; w < icache_pkg::NUM_WAYS; w++) begin : g_way
    // Write enable is this way's bit of the select
    icache_ram #(
      .payload_t (icache_pkg::word_t),
      .ADDR_BITS ($bits(icache_pkg::data_adr_t))
    ) u_data_ram (
      .clk      (clk),
      .rd_adr_i (rd_adr_i),
      .wr_adr_i (wr_adr_i),
      .wr_en_i  (wr_way_i[w]),
      .wr_dat_i (wr_dat_i),
      .rd_dat_o (rd_dat[w])
    );
  end

  // Controller picks the hit way
  assign rd_dat0_o = rd_dat[0];
  assign rd_dat1_o = rd_dat[1];

endmodule

`default_nettype wire

// ==== icache_pkg.sv ====
/* Geometry, address field helpers and tag row layout of the two-way instruction cache.
   Every cache module refers to these by scoped names. */
`default_nettype none

package icache_pkg;

  ////////////////////////////////////////////////////////////
  // Geometry
  ////////////////////////////////////////////////////////////

  localparam int unsigned ADDR_W         = 32;
  localparam int unsigned WORD_W         = 32;
  // Byte offset within a 32-byte line
  localparam int unsigned OFFSET_W       = 5;
  localparam int unsigned WORD_SEL_W     = 3;
  localparam int unsigned WORDS_PER_LINE = 8;
  localparam int unsigned SET_W          = 9;
  // Everything above set and offset
  localparam int unsigned TAG_W          = ADDR_W - SET_W - OFFSET_W;
  localparam int unsigned NUM_WAYS       = 2;

  // Instruction cache block invalidate register, SPR group 4
  localparam logic [15:0] SPR_ICBIR_ADDR = 16'h2002;

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [SET_W-1:0]      set_t;
  typedef logic [TAG_W-1:0]      tag_t;
  typedef logic [WORD_SEL_W-1:0] word_sel_t;

  // Set in the upper bits, word in the lower bits
  typedef logic [SET_W+WORD_SEL_W-1:0] data_adr_t;

  typedef struct packed {
    logic valid;
    tag_t tag;
  } tag_way_t;

  // LRU names the way to replace next
  typedef struct packed {
    logic                     lru;
    tag_way_t [NUM_WAYS-1:0] way;
  } tag_row_t;

  ////////////////////////////////////////////////////////////
  // Address field extraction
  ////////////////////////////////////////////////////////////

  function automatic tag_t adr_tag(input logic [ADDR_W-1:0] adr);
    return adr[OFFSET_W+SET_W +: TAG_W];
  endfunction

  function automatic set_t adr_set(input logic [ADDR_W-1:0] adr);
    return adr[OFFSET_W +: SET_W];
  endfunction

  // Word index sits right above the two byte bits
  function automatic word_sel_t adr_word(input logic [ADDR_W-1:0] adr);
    return adr[OFFSET_W-WORD_SEL_W +: WORD_SEL_W];
  endfunction

endpackage

`default_nettype wire

// ==== icache_ram.sv ====
/* Registered-read memory with one read and one write port, payload set by type.
   Serves tag rows and instruction words alike. */
`timescale 1ns/1ps
`default_nettype none

module icache_ram #(
  parameter type         payload_t = logic,
  parameter int unsigned ADDR_BITS = 9
) (
  input  logic                 clk,
  input  logic [ADDR_BITS-1:0] rd_adr_i,
  input  logic [ADDR_BITS-1:0] wr_adr_i,
  input  logic                 wr_en_i,
  input  payload_t             wr_dat_i,
  output payload_t             rd_dat_o
);

  // Storage, one entry per address
  payload_t mem_q [2**ADDR_BITS];

  // Read returns old contents on a same-address write
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem_q[wr_adr_i] <= wr_dat_i;
    end
    rd_dat_o <= mem_q[rd_adr_i];
  end

endmodule

`default_nettype wire

// ==== icache_tag_array.sv ====
/* Tag rows for both ways plus the per-way compare against the lookup tag.
   Hits are valid one cycle after the set is presented. */
`timescale 1ns/1ps
`default_nettype none

module icache_tag_array (
  input  logic                             clk,
  input  icache_pkg::set_t                 rd_set_i,
  input  icache_pkg::tag_t                 cmp_tag_i,
  input  icache_pkg::set_t                 wr_set_i,
  input  logic                             wr_en_i,
  input  icache_pkg::tag_row_t             wr_row_i,
  output icache_pkg::tag_row_t             rd_row_o,
  output logic [icache_pkg::NUM_WAYS-1:0] way_hit_o
);

  ////////////////////////////////////////////////////////////
  // Tag memory
  ////////////////////////////////////////////////////////////

  icache_pkg::tag_row_t row;

  // One row per set
  icache_ram #(
    .payload_t (icache_pkg::tag_row_t),
    .ADDR_BITS (icache_pkg::SET_W)
  ) u_tag_ram (
    .clk      (clk),
    .rd_adr_i (rd_set_i),
    .wr_adr_i (wr_set_i),
    .wr_en_i  (wr_en_i),
    .wr_dat_i (wr_row_i),
    .rd_dat_o (row)
  );

  assign rd_row_o = row;

  ////////////////////////////////////////////////////////////
  // Tag compare
  ////////////////////////////////////////////////////////////

  // Stored tag must match and the way must hold a line
  always_comb begin
    for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
      way_hit_o[w] = row.way[w].valid && (row.way[w].tag == cmp_tag_i);
    end
  end

endmodule

`default_nettype wire

// ==== icache_top.sv ====
/* Two-way instruction cache top: tag array and data array side by side,
   joined by the controller. */
`timescale 1ns/1ps
`default_nettype none

module icache_top (
  input  logic                          clk,
  input  logic                          rst,
  // CPU fetch
  input  logic                          cpu_req_i,
  input  logic [icache_pkg::ADDR_W-1:0] cpu_adr_i,
  output logic                          cpu_ack_o,
  output icache_pkg::word_t             cpu_dat_o,
  // Refill memory
  output logic                          refill_req_o,
  output logic [icache_pkg::ADDR_W-1:0] refill_adr_o,
  input  logic                          mem_we_i,
  input  icache_pkg::word_t             mem_dat_i,
  output logic                          refill_done_o,
  // SPR bus
  input  logic                          spr_stb_i,
  input  logic                          spr_we_i,
  input  logic [15:0]                   spr_addr_i,
  input  logic [icache_pkg::ADDR_W-1:0] spr_dat_i,
  output logic                          spr_ack_o
);

  ////////////////////////////////////////////////////////////
  // Array to controller wiring
  ////////////////////////////////////////////////////////////

  icache_pkg::set_t               tag_rd_set;
  icache_pkg::tag_t               cmp_tag;
  icache_pkg::set_t               tag_wr_set;
  logic                           tag_wr_en;
  icache_pkg::tag_row_t           tag_wr_row;
  icache_pkg::tag_row_t           tag_rd_row;
  logic [icache_pkg::NUM_WAYS-1:0] way_hit;

  icache_pkg::data_adr_t           data_rd_adr;
  icache_pkg::data_adr_t           data_wr_adr;
  logic [icache_pkg::NUM_WAYS-1:0] data_wr_way;
  icache_pkg::word_t               data_wr_dat;
  icache_pkg::word_t               rd_dat0;
  icache_pkg::word_t               rd_dat1;

  icache_tag_array u_tag_array (
    .clk       (clk),
    .rd_set_i  (tag_rd_set),
    .cmp_tag_i (cmp_tag),
    .wr_set_i  (tag_wr_set),
    .wr_en_i   (tag_wr_en),
    .wr_row_i  (tag_wr_row),
    .rd_row_o  (tag_rd_row),
    .way_hit_o (way_hit)
  );

  icache_data_array u_data_array (
    .clk       (clk),
    .rd_adr_i  (data_rd_adr),
    .wr_adr_i  (data_wr_adr),
    .wr_way_i  (data_wr_way),
    .wr_dat_i  (data_wr_dat),
    .rd_dat0_o (rd_dat0),
    .rd_dat1_o (rd_dat1)
  );

  icache_ctrl u_ctrl (
    .clk           (clk),
    .rst           (rst),
    .cpu_req_i     (cpu_req_i),
    .cpu_adr_i     (cpu_adr_i),
    .cpu_ack_o     (cpu_ack_o),
    .cpu_dat_o     (cpu_dat_o),
    .refill_req_o  (refill_req_o),
    .refill_adr_o  (refill_adr_o),
    .mem_we_i      (mem_we_i),
    .mem_dat_i     (mem_dat_i),
    .refill_done_o (refill_done_o),
    .spr_stb_i     (spr_stb_i),
    .spr_we_i      (spr_we_i),
    .spr_addr_i    (spr_addr_i),
    .spr_dat_i     (spr_dat_i),
    .spr_ack_o     (spr_ack_o),
    .tag_rd_set_o  (tag_rd_set),
    .cmp_tag_o     (cmp_tag),
    .tag_wr_set_o  (tag_wr_set),
    .tag_wr_en_o   (tag_wr_en),
    .tag_wr_row_o  (tag_wr_row),
    .rd_row_i      (tag_rd_row),
    .way_hit_i     (way_hit),
    .data_rd_adr_o (data_rd_adr),
    .data_wr_adr_o (data_wr_adr),
    .data_wr_way_o (data_wr_way),
    .data_wr_dat_o (data_wr_dat),
    .rd_dat0_i     (rd_dat0),
    .rd_dat1_i     (rd_dat1)
  );

endmodule

`default_nettype wire

// ==== tb_icache.sv ====
/* Self-checking testbench for the two-way instruction cache.
   Runs directed and random fetches against a refill memory model and a reference cache model. */
`timescale 1ns/1ps
`default_nettype none

module tb_icache;

  localparam int NUM_SETS     = 1 << icache_pkg::SET_W;
  localparam int RESET_CYCLES = 16;
  localparam int DRIVE_DLY    = 5;
  localparam int MAX_GAP      = 3;
  localparam int NUM_DIRECTED = 24;
  localparam int NUM_RANDOM   = 300;
  // Lookup, miss cycle, request wait, eight words with gaps, reissue
  localparam int REFILL_WORST = 6 + icache_pkg::WORDS_PER_LINE * (MAX_GAP + 1);
  localparam int CYCLE_LIMIT  = RESET_CYCLES + 4 * NUM_SETS + 4 * NUM_RANDOM + 64 +
                                (NUM_DIRECTED + NUM_RANDOM) * REFILL_WORST;

  logic        clk = 1'b0;
  logic        rst;
  logic        cpu_req_i;
  logic [31:0] cpu_adr_i;
  logic        cpu_ack_o;
  logic [31:0] cpu_dat_o;
  logic        refill_req_o;
  logic [31:0] refill_adr_o;
  logic        mem_we_i;
  logic [31:0] mem_dat_i;
  logic        refill_done_o;
  logic        spr_stb_i;
  logic        spr_we_i;
  logic [15:0] spr_addr_i;
  logic [31:0] spr_dat_i;
  logic        spr_ack_o;

  int          cycle_cnt = 0;
  logic [15:0] lfsr_q    = 16'd38236;

  // Reference cache state per set
  logic                 ref_valid [NUM_SETS][2];
  icache_pkg::tag_t     ref_tag   [NUM_SETS][2];
  logic                 ref_lru   [NUM_SETS];

  // Pending lookup results, one entry per request taken
  int                   exp_cyc_q [$];
  logic                 exp_hit_q [$];
  logic [31:0]          exp_dat_q [$];

  icache_pkg::tag_t     tag_pool [4];
  icache_pkg::set_t     set_pool [4];

  icache_top dut0 (
    .clk           (clk),
    .rst           (rst),
    .cpu_req_i     (cpu_req_i),
    .cpu_adr_i     (cpu_adr_i),
    .cpu_ack_o     (cpu_ack_o),
    .cpu_dat_o     (cpu_dat_o),
    .refill_req_o  (refill_req_o),
    .refill_adr_o  (refill_adr_o),
    .mem_we_i      (mem_we_i),
    .mem_dat_i     (mem_dat_i),
    .refill_done_o (refill_done_o),
    .spr_stb_i     (spr_stb_i),
    .spr_we_i      (spr_we_i),
    .spr_addr_i    (spr_addr_i),
    .spr_dat_i     (spr_dat_i),
    .spr_ack_o     (spr_ack_o)
  );

  always #50 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // Galois LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic lsb;
    lsb = s[0];
    s   = s >> 1;
    if (lsb) begin
      s = s ^ 16'hB400;
    end
    return s;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // Memory contents as a hash of the word address
  function automatic logic [31:0] mem_word(input logic [31:0] adr);
    logic [31:0] x;
    x = {adr[31:2], 2'b00} ^ 32'h3C6E_F372;
    x = x * 32'h9E37_79B9;
    return x ^ (x >> 15);
  endfunction

  function automatic logic [31:0] make_adr(input icache_pkg::tag_t tag,
                                           input icache_pkg::set_t set,
                                           input logic [2:0] word);
    return {tag, set, word, 2'b00};
  endfunction

  function automatic icache_pkg::set_t set_of(input logic [31:0] adr);
    return adr[icache_pkg::OFFSET_W +: icache_pkg::SET_W];
  endfunction

  function automatic icache_pkg::tag_t tag_of(input logic [31:0] adr);
    return adr[icache_pkg::ADDR_W-1 -: icache_pkg::TAG_W];
  endfunction

  // Reference lookup: hit way, or -1 on a miss
  function automatic int ref_lookup(input logic [31:0] adr);
    for (int w = 0; w < 2; w++) begin
      if (ref_valid[set_of(adr)][w] && (ref_tag[set_of(adr)][w] == tag_of(adr))) begin
        return w;
      end
    end
    return -1;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h at cycle %0d",
               name, got, exp, cycle_cnt);
      $display("Test failures found");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  task automatic fail_run(input string why);
    $display("%s at cycle %0d", why, cycle_cnt);
    $display("Test failures found");
    $fatal(1, "Run aborted");
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      next_cycle();
      cpu_req_i = 1'b0;
      mem_we_i  = 1'b0;
      spr_stb_i = 1'b0;
      spr_we_i  = 1'b0;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Cycle counter, timeout and acknowledge compare
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      fail_run("Timeout, cycle limit reached");
    end
  end

  // Outputs settle well before the falling edge
  always @(negedge clk) begin
    if (!rst) begin
      if ((exp_cyc_q.size() != 0) && (exp_cyc_q[0] == cycle_cnt)) begin
        check_value("cpu_ack_o", cpu_ack_o, exp_hit_q[0]);
        if (exp_hit_q[0]) begin
          check_value("cpu_dat_o", cpu_dat_o, exp_dat_q[0]);
        end
        void'(exp_cyc_q.pop_front());
        void'(exp_hit_q.pop_front());
        void'(exp_dat_q.pop_front());
      end else begin
        check_value("cpu_ack_o", cpu_ack_o, 32'd0);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Memory model and CPU side stimulus
  ////////////////////////////////////////////////////////////

  // Called in the miss cycle; answers with the missed word first and wraps
  task automatic serve_refill(input logic [31:0] adr);
    int         waits;
    int         gap;
    logic [2:0] ws;
    int         victim;
    waits = 0;
    @(negedge clk);
    while (!refill_req_o) begin
      waits++;
      if (waits > 3) begin
        fail_run("Refill request not raised after a miss");
      end
      @(negedge clk);
    end
    check_value("refill_adr_o", refill_adr_o, {adr[31:2], 2'b00});
    for (int i = 0; i < icache_pkg::WORDS_PER_LINE; i++) begin
      gap = rand_bits(2);
      repeat (gap) begin
        next_cycle();
        mem_we_i  = 1'b0;
        // Stray fetches during refill must be dropped
        cpu_req_i = rand_bits(1);
        cpu_adr_i = rand_bits(32);
        @(negedge clk);
        check_value("refill_done_o", refill_done_o, 32'd0);
      end
      ws = adr[4:2] + i[2:0];
      next_cycle();
      mem_we_i  = 1'b1;
      mem_dat_i = mem_word({adr[31:5], ws, 2'b00});
      cpu_req_i = rand_bits(1);
      cpu_adr_i = rand_bits(32);
      @(negedge clk);
      check_value("refill_done_o", refill_done_o, (i == icache_pkg::WORDS_PER_LINE - 1));
      check_value("refill_req_o", refill_req_o, 32'd1);
    end
    next_cycle();
    mem_we_i  = 1'b0;
    mem_dat_i = '0;
    cpu_req_i = 1'b0;
    @(negedge clk);
    check_value("refill_req_o", refill_req_o, 32'd0);
    // Victim is the LRU way, new line makes the other way next
    victim = ref_lru[set_of(adr)];
    ref_valid[set_of(adr)][victim] = 1'b1;
    ref_tag[set_of(adr)][victim]   = tag_of(adr);
    ref_lru[set_of(adr)]           = (victim == 0);
  endtask

  // Issue one fetch; a miss is refilled and reissued at a random word of the line
  task automatic access(input logic [31:0] adr);
    int          way;
    logic [31:0] re_adr;
    logic [2:0]  re_word;
    way = ref_lookup(adr);
    next_cycle();
    cpu_req_i = 1'b1;
    cpu_adr_i = adr;
    exp_cyc_q.push_back(cycle_cnt + 1);
    exp_hit_q.push_back(way >= 0);
    exp_dat_q.push_back(mem_word(adr));
    if (way >= 0) begin
      ref_lru[set_of(adr)] = (way == 0);
    end else begin
      next_cycle();
      cpu_req_i = 1'b0;
      serve_refill(adr);
      re_word = rand_bits(3);
      re_adr  = {adr[31:5], re_word, 2'b00};
      way     = ref_lookup(re_adr);
      next_cycle();
      cpu_req_i = 1'b1;
      cpu_adr_i = re_adr;
      exp_cyc_q.push_back(cycle_cnt + 1);
      exp_hit_q.push_back(1'b1);
      exp_dat_q.push_back(mem_word(re_adr));
      ref_lru[set_of(re_adr)] = (way == 0);
    end
  endtask

  // Block invalidate through the SPR bus with noise in the unused data bits
  task automatic invalidate_set(input icache_pkg::set_t set);
    logic [17:0] hi_bits;
    logic [4:0]  lo_bits;
    idle_cycles(1);
    next_cycle();
    hi_bits    = rand_bits(18);
    lo_bits    = rand_bits(5);
    spr_stb_i  = 1'b1;
    spr_we_i   = 1'b1;
    spr_addr_i = icache_pkg::SPR_ICBIR_ADDR;
    spr_dat_i  = {hi_bits, set, lo_bits};
    @(negedge clk);
    check_value("spr_ack_o", spr_ack_o, 32'd0);
    next_cycle();
    spr_stb_i = 1'b0;
    spr_we_i  = 1'b0;
    @(negedge clk);
    check_value("spr_ack_o", spr_ack_o, 32'd1);
    ref_valid[set][0] = 1'b0;
    ref_valid[set][1] = 1'b0;
    ref_lru[set]      = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rst        = 1'b1;
    cpu_req_i  = 1'b0;
    cpu_adr_i  = '0;
    mem_we_i   = 1'b0;
    mem_dat_i  = '0;
    spr_stb_i  = 1'b0;
    spr_we_i   = 1'b0;
    spr_addr_i = '0;
    spr_dat_i  = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    rst = 1'b0;

    // Tag memory starts unknown
    for (int s = 0; s < NUM_SETS; s++) begin
      invalidate_set(icache_pkg::set_t'(s));
    end

    // Strobe to another SPR gets no acknowledge
    next_cycle();
    spr_stb_i  = 1'b1;
    spr_we_i   = 1'b1;
    spr_addr_i = icache_pkg::SPR_ICBIR_ADDR ^ 16'h0001;
    repeat (3) begin
      @(negedge clk);
      check_value("spr_ack_o", spr_ack_o, 32'd0);
      next_cycle();
    end
    spr_stb_i = 1'b0;
    spr_we_i  = 1'b0;
    @(negedge clk);
    check_value("cpu_ack_o", cpu_ack_o, 32'd0);
    check_value("refill_req_o", refill_req_o, 32'd0);
    check_value("refill_done_o", refill_done_o, 32'd0);
    check_value("spr_ack_o", spr_ack_o, 32'd0);

    // First miss, refill, then a burst of hits over the line
    for (int w = 0; w < 8; w++) begin
      access(make_adr(18'h01234, 9'h0A5, w[2:0]));
    end
    // Three tags in one set, LRU picks the victim
    access(make_adr(18'h2BEEF, 9'h0A5, 3'd3));
    access(make_adr(18'h01234, 9'h0A5, 3'd6));
    access(make_adr(18'h15555, 9'h0A5, 3'd1));
    access(make_adr(18'h01234, 9'h0A5, 3'd2));
    access(make_adr(18'h2BEEF, 9'h0A5, 3'd7));
    access(make_adr(18'h15555, 9'h0A5, 3'd0));
    // One set invalidated, a neighbor set keeps its line
    access(make_adr(18'h00777, 9'h1F0, 3'd4));
    invalidate_set(9'h0A5);
    access(make_adr(18'h15555, 9'h0A5, 3'd5));
    access(make_adr(18'h00777, 9'h1F0, 3'd0));

    // Small pools so lines get reused and sets conflict
    for (int i = 0; i < 4; i++) begin
      tag_pool[i] = icache_pkg::tag_t'(rand_bits(18));
      set_pool[i] = icache_pkg::set_t'(rand_bits(9));
    end
    for (int i = 0; i < NUM_RANDOM; i++) begin
      if (rand_bits(4) == 0) begin
        invalidate_set(set_pool[rand_bits(2)]);
      end
      access(make_adr(tag_pool[rand_bits(2)], set_pool[rand_bits(2)], rand_bits(3)));
    end

    idle_cycles(4);
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
icache_pkg.sv
icache_ram.sv
icache_tag_array.sv
icache_data_array.sv
icache_ctrl.sv
icache_top.sv
tb_icache.sv
